// ==== rtl/fetch_pkg.sv ====
package fetch_pkg;

    // Address and reset values
    localparam int ADDR_W = 64;
    localparam logic [ADDR_W-1:0] RESET_PC = 64'h0000_1000;
    localparam logic [ADDR_W-1:0] ADDR_ALL_ONES = '1;

    // Fetch queue sizing
    localparam int QUEUE_DEPTH = 4;
    // Leaves room for the fetches still in flight
    localparam int QUEUE_STOP_LEVEL = 2;
    localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
    localparam int QUEUE_CNT_W = QUEUE_PTR_W + 1;

    typedef enum logic [1:0] {
        IDLE            = 2'd0,
        WAIT_REQ_ACCEPT = 2'd1,
        WAIT_RESP       = 2'd2
    } fetch_state_e;

    // One memory word, or two 32-bit instructions
    typedef union packed {
        logic [63:0]      w64;
        logic [1:0][31:0] slot;
    } fetch_word_u;

    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] addr;
    } mem_req_s;

    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] addr;
        fetch_word_u       data;
        logic              load_fault;
    } mem_resp_s;

    typedef struct packed {
        logic [ADDR_W-1:0] pc;
        fetch_word_u       word;
        logic              load_fault;
    } fetched_s;

    typedef struct packed {
        logic [ADDR_W-1:0] pc;
        logic [31:0]       instr;
        logic              load_fault;
    } decode_instr_s;

    typedef struct packed {
        fetch_state_e      state;
        logic              req_valid;
        logic [ADDR_W-1:0] req_addr;
        logic              resp_ready;
        logic [ADDR_W-1:0] mem_resp_shadow;
        logic [ADDR_W-1:0] pc;
        fetch_word_u       word;
        logic              load_fault;
        logic              progbuf_ena;
        logic              out_valid;
    } fetch_regs_s;

    localparam fetch_regs_s FETCH_REGS_RESET = '{
        state:           IDLE,
        req_valid:       1'b0,
        req_addr:        ADDR_ALL_ONES,
        resp_ready:      1'b0,
        mem_resp_shadow: ADDR_ALL_ONES,
        pc:              ADDR_ALL_ONES,
        word:            '0,
        load_fault:      1'b0,
        progbuf_ena:     1'b0,
        out_valid:       1'b0
    };

endpackage

// ==== rtl/pc_predictor.sv ====
`timescale 1ns/100ps

module pc_predictor
    import fetch_pkg::*;
(
    input  logic              i_clk,
    input  logic              i_nrst,
    input  logic              i_flush,
    input  logic [ADDR_W-1:0] i_flush_pc,
    input  logic              i_progbuf_ena,
    input  logic              i_queue_stop,
    input  mem_req_s          i_mem_req,
    input  logic              i_mem_req_ready,
    output logic              o_bp_valid,
    output logic [ADDR_W-1:0] o_bp_pc
);

    logic [ADDR_W-1:0] next_pc;
    logic              req_fire;

    // Request handshake on the memory port
    assign req_fire = i_mem_req.valid && i_mem_req_ready;

    // Sequential PC, a flush redirect wins over an accept in the same cycle
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            next_pc <= RESET_PC;
        end else if (i_flush) begin
            next_pc <= i_flush_pc;
        end else if (req_fire) begin
            next_pc <= i_mem_req.addr + ADDR_W'(4);
        end
    end

    // No new offers while the queue is nearly full or the debug buffer runs
    assign o_bp_valid = !i_queue_stop && !i_progbuf_ena;
    assign o_bp_pc    = next_pc;

    // The fetch stage only ever launches the address offered here, even
    // after re-writing a waiting request
    a_accept_matches_offer: assert property (
        @(posedge i_clk) disable iff (!i_nrst)
        (req_fire && !i_flush) |-> (i_mem_req.addr == next_pc)
    );

endmodule

// ==== rtl/instr_fetch.sv ====
`timescale 1ns/100ps

module instr_fetch
    import fetch_pkg::*;
(
    input  logic              i_clk,
    input  logic              i_nrst,
    input  logic              i_bp_valid,
    input  logic [ADDR_W-1:0] i_bp_pc,
    output logic [ADDR_W-1:0] o_requested_pc,
    output logic [ADDR_W-1:0] o_fetching_pc,
    input  logic              i_mem_req_ready,
    output mem_req_s          o_mem_req,
    input  mem_resp_s         i_mem_resp,
    output logic              o_mem_resp_ready,
    input  logic              i_flush,
    input  logic              i_progbuf_ena,
    input  logic [ADDR_W-1:0] i_progbuf_pc,
    input  logic [31:0]       i_progbuf_instr,
    output logic              o_fetched_valid,
    output fetched_s          o_fetched
);

    fetch_regs_s r;
    fetch_regs_s rin;
    logic        req_fire;

    // A second request waits in WAIT_RESP and goes out with the response
    assign o_mem_req.valid  = r.req_valid && ((r.state != WAIT_RESP) || i_mem_resp.valid);
    assign o_mem_req.addr   = r.req_addr;
    assign req_fire         = o_mem_req.valid && i_mem_req_ready;
    assign o_mem_resp_ready = r.resp_ready;
    assign o_requested_pc   = r.req_addr;
    assign o_fetching_pc    = r.mem_resp_shadow;
    assign o_fetched_valid  = r.out_valid;
    assign o_fetched.pc         = r.pc;
    assign o_fetched.word       = r.word;
    assign o_fetched.load_fault = r.load_fault;

    always_comb begin
        fetch_regs_s v;

        v = r;
        v.out_valid = 1'b0;

        case (r.state)
            IDLE: begin
                v.req_valid = 1'b0;
                v.progbuf_ena = 1'b0;
                if (i_progbuf_ena) begin
                    v.progbuf_ena = 1'b1;
                    // One instruction per entry into the program buffer
                    if (!r.progbuf_ena) begin
                        v.out_valid = 1'b1;
                        v.pc = {i_progbuf_pc[ADDR_W-1:3], 1'b0, i_progbuf_pc[1:0]};
                        v.word.slot[0] = i_progbuf_instr;
                        v.word.slot[1] = '0;
                        v.load_fault = 1'b0;
                    end
                end else if (i_bp_valid) begin
                    v.req_valid = 1'b1;
                    v.req_addr = i_bp_pc;
                    v.state = WAIT_REQ_ACCEPT;
                end
            end
            WAIT_REQ_ACCEPT: begin
                if (req_fire) begin
                    v.mem_resp_shadow = r.req_addr;
                    v.req_valid = 1'b0;
                    v.state = WAIT_RESP;
                end else if (i_bp_valid) begin
                    // Follow the newest offer until the memory takes it
                    v.req_addr = i_bp_pc;
                end
            end
            WAIT_RESP: begin
                if (i_mem_resp.valid) begin
                    // Stale responses from before a flush miss the shadow
                    if (i_mem_resp.addr[ADDR_W-1:3] == r.mem_resp_shadow[ADDR_W-1:3]) begin
                        v.out_valid = 1'b1;
                        v.pc = r.mem_resp_shadow;
                        v.word = i_mem_resp.data;
                        v.load_fault = i_mem_resp.load_fault;
                    end
                    if (req_fire) begin
                        v.mem_resp_shadow = r.req_addr;
                        v.req_valid = 1'b0;
                    end else if (r.req_valid) begin
                        v.state = WAIT_REQ_ACCEPT;
                        if (i_bp_valid) begin
                            v.req_addr = i_bp_pc;
                        end
                    end else if (i_bp_valid) begin
                        v.req_valid = 1'b1;
                        v.req_addr = i_bp_pc;
                        v.state = WAIT_REQ_ACCEPT;
                    end else begin
                        v.req_addr = ADDR_ALL_ONES;
                        v.state = IDLE;
                    end
                end else if (i_bp_valid) begin
                    // Prepare the next request behind the pending one
                    v.req_valid = 1'b1;
                    v.req_addr = i_bp_pc;
                end
            end
            default: begin
                v.state = IDLE;
            end
        endcase

        if (i_flush) begin
            v.req_valid = 1'b0;
            v.req_addr = ADDR_ALL_ONES;
            v.mem_resp_shadow = ADDR_ALL_ONES;
            v.out_valid = 1'b0;
            v.pc = ADDR_ALL_ONES;
            v.word.w64 = '0;
            v.load_fault = 1'b0;
            v.progbuf_ena = 1'b0;
            // Keep waiting so an old response can be absorbed
            if (v.state != WAIT_RESP) begin
                v.state = IDLE;
            end
        end

        v.resp_ready = (v.state == WAIT_RESP);
        rin = v;
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            r <= FETCH_REGS_RESET;
        end else begin
            r <= rin;
        end
    end

    // Request stays pending until the memory takes it or a flush drops it
    a_req_held: assert property (
        @(posedge i_clk) disable iff (!i_nrst)
        (o_mem_req.valid && !i_mem_req_ready && !i_flush) |=> o_mem_req.valid
    );

    // Memory only answers what this stage is waiting for
    a_resp_in_wait: assert property (
        @(posedge i_clk) disable iff (!i_nrst)
        i_mem_resp.valid |-> (r.state == WAIT_RESP)
    );

    a_state_legal: assert property (
        @(posedge i_clk) disable iff (!i_nrst)
        r.state inside {IDLE, WAIT_REQ_ACCEPT, WAIT_RESP}
    );

endmodule

// ==== rtl/fetch_queue.sv ====
`timescale 1ns/100ps

module fetch_queue
    import fetch_pkg::*;
(
    input  logic          i_clk,
    input  logic          i_nrst,
    input  logic          i_flush,
    input  logic          i_fetched_valid,
    input  fetched_s      i_fetched,
    output logic          o_queue_stop,
    output logic          o_dec_valid,
    output decode_instr_s o_dec,
    input  logic          i_dec_ready
);

    fetched_s               entries [QUEUE_DEPTH];
    logic [QUEUE_PTR_W-1:0] wr_ptr;
    logic [QUEUE_PTR_W-1:0] rd_ptr;
    logic [QUEUE_CNT_W-1:0] count;
    logic                   push;
    logic                   pop;
    fetched_s               head;

    // Output of the fetch stage in a flush cycle is already stale
    assign push = i_fetched_valid && !i_flush;
    assign pop  = o_dec_valid && i_dec_ready;

    always_ff @(posedge i_clk) begin
        if (push) begin
            entries[wr_ptr] <= i_fetched;
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (i_flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign o_queue_stop = (count >= QUEUE_CNT_W'(QUEUE_STOP_LEVEL));

    // Head entry, picking the half of the word addressed by pc[2]
    assign head             = entries[rd_ptr];
    assign o_dec_valid      = (count != '0);
    assign o_dec.pc         = head.pc;
    assign o_dec.instr      = head.word.slot[head.pc[2]];
    assign o_dec.load_fault = head.load_fault;

    // Upstream throttling must leave room for fetches in flight
    a_no_push_full: assert property (
        @(posedge i_clk) disable iff (!i_nrst)
        push |-> (count < QUEUE_CNT_W'(QUEUE_DEPTH))
    );

    a_count_bound: assert property (
        @(posedge i_clk) disable iff (!i_nrst)
        count <= QUEUE_CNT_W'(QUEUE_DEPTH)
    );

endmodule

// ==== rtl/fetch_top.sv ====
`timescale 1ns/100ps

module fetch_top
    import fetch_pkg::*;
(
    input  logic              i_clk,
    input  logic              i_nrst,
    input  logic              i_flush,
    input  logic [ADDR_W-1:0] i_flush_pc,
    input  logic              i_progbuf_ena,
    input  logic [ADDR_W-1:0] i_progbuf_pc,
    input  logic [31:0]       i_progbuf_instr,
    output mem_req_s          o_mem_req,
    input  logic              i_mem_req_ready,
    input  mem_resp_s         i_mem_resp,
    output logic              o_mem_resp_ready,
    output logic              o_dec_valid,
    output decode_instr_s     o_dec,
    input  logic              i_dec_ready
);

    logic              bp_valid;
    logic [ADDR_W-1:0] bp_pc;
    logic              queue_stop;
    logic              fetched_valid;
    fetched_s          fetched;

    pc_predictor pred0 (
        .i_clk           (i_clk),
        .i_nrst          (i_nrst),
        .i_flush         (i_flush),
        .i_flush_pc      (i_flush_pc),
        .i_progbuf_ena   (i_progbuf_ena),
        .i_queue_stop    (queue_stop),
        .i_mem_req       (o_mem_req),
        .i_mem_req_ready (i_mem_req_ready),
        .o_bp_valid      (bp_valid),
        .o_bp_pc         (bp_pc)
    );

    // Requested and in-flight addresses are left for debug probing
    instr_fetch fetch0 (
        .i_clk            (i_clk),
        .i_nrst           (i_nrst),
        .i_bp_valid       (bp_valid),
        .i_bp_pc          (bp_pc),
        .o_requested_pc   (),
        .o_fetching_pc    (),
        .i_mem_req_ready  (i_mem_req_ready),
        .o_mem_req        (o_mem_req),
        .i_mem_resp       (i_mem_resp),
        .o_mem_resp_ready (o_mem_resp_ready),
        .i_flush          (i_flush),
        .i_progbuf_ena    (i_progbuf_ena),
        .i_progbuf_pc     (i_progbuf_pc),
        .i_progbuf_instr  (i_progbuf_instr),
        .o_fetched_valid  (fetched_valid),
        .o_fetched        (fetched)
    );

    fetch_queue queue0 (
        .i_clk           (i_clk),
        .i_nrst          (i_nrst),
        .i_flush         (i_flush),
        .i_fetched_valid (fetched_valid),
        .i_fetched       (fetched),
        .o_queue_stop    (queue_stop),
        .o_dec_valid     (o_dec_valid),
        .o_dec           (o_dec),
        .i_dec_ready     (i_dec_ready)
    );

endmodule

// ==== testbench/fetch_mem_model.sv ====
`timescale 1ns/100ps

module fetch_mem_model
    import fetch_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_nrst,
    input  mem_req_s  i_mem_req,
    output logic      o_mem_req_ready,
    output mem_resp_s o_mem_resp,
    input  logic      i_mem_resp_ready
);

    // Word index to {fault, data}
    logic [64:0]       mem [logic [60:0]];
    logic [ADDR_W-1:0] pend_addr [$];
    int                pend_due [$];
    int                cyc;

    task automatic write_word(input logic [63:0] addr, input logic [63:0] data,
                              input logic fault);
        mem[addr[63:3]] = {fault, data};
    endtask

    // Unloaded words get a pattern built from the whole aligned address
    function automatic logic [64:0] read_word(input logic [63:0] addr);
        logic [63:0] a;
        a = {addr[63:3], 3'b000};
        if (mem.exists(a[63:3])) begin
            return mem[a[63:3]];
        end
        return {1'b0, a[31:0] ^ a[63:32], ~a[31:0]};
    endfunction

    initial begin
        logic        fire;
        logic        taken;
        logic        rdy_now;
        logic [64:0] rd;

        o_mem_req_ready = 1'b0;
        o_mem_resp = '0;
        cyc = 0;
        forever begin
            // Sample the handshake mid-cycle, update on the next edge
            @(negedge i_clk);
            fire = i_mem_req.valid && o_mem_req_ready;
            taken = o_mem_resp.valid;
            rdy_now = i_mem_resp_ready;
            @(posedge i_clk);
            cyc = cyc + 1;
            if (!i_nrst) begin
                pend_addr.delete();
                pend_due.delete();
                o_mem_req_ready <= 1'b0;
                o_mem_resp <= '0;
            end else begin
                if (taken) begin
                    void'(pend_addr.pop_front());
                    void'(pend_due.pop_front());
                end
                if (fire) begin
                    pend_addr.push_back(i_mem_req.addr);
                    pend_due.push_back(cyc + int'($urandom % 4));
                end
                o_mem_req_ready <= (($urandom % 4) != 0);
                // Never two response cycles back to back
                if (!taken && rdy_now && pend_addr.size() > 0 && pend_due[0] <= cyc) begin
                    rd = read_word(pend_addr[0]);
                    o_mem_resp.valid <= 1'b1;
                    o_mem_resp.addr <= pend_addr[0];
                    o_mem_resp.data.w64 <= rd[63:0];
                    o_mem_resp.load_fault <= rd[64];
                end else begin
                    o_mem_resp <= '0;
                end
            end
        end
    end

endmodule

// ==== testbench/tb_fetch_top.sv ====
`timescale 1ns/100ps

module tb_fetch_top;
    import fetch_pkg::*;

    logic              i_clk;
    logic              i_nrst;
    logic              i_flush;
    logic [ADDR_W-1:0] i_flush_pc;
    logic              i_progbuf_ena;
    logic [ADDR_W-1:0] i_progbuf_pc;
    logic [31:0]       i_progbuf_instr;
    mem_req_s          o_mem_req;
    logic              i_mem_req_ready;
    mem_resp_s         i_mem_resp;
    logic              o_mem_resp_ready;
    logic              o_dec_valid;
    decode_instr_s     o_dec;
    logic              i_dec_ready;

    logic [63:0] exp_pc [$];
    logic [63:0] exp_instr [$];
    logic [63:0] exp_fault [$];
    int          cmd_idx [$];
    int          cmd_kind [$];
    logic [63:0] cmd_a [$];
    logic [63:0] cmd_b [$];
    logic [63:0] cmd_c [$];
    int          errors;
    int          stall_left;
    int          pb_req_cnt;
    int          stall_fire_cnt;
    bit          stall_end_req_valid;

    fetch_top dut0 (.*);

    fetch_mem_model mem0 (
        .i_clk            (i_clk),
        .i_nrst           (i_nrst),
        .i_mem_req        (o_mem_req),
        .o_mem_req_ready  (i_mem_req_ready),
        .o_mem_resp       (i_mem_resp),
        .i_mem_resp_ready (o_mem_resp_ready)
    );

    initial begin
        i_clk = 1'b0;
        forever #20 i_clk = ~i_clk;
    end

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("ERR t=%0t %s expected %h got %h", $time, name, expected, actual);
            errors = errors + 1;
        end
    endtask

    task automatic load_patterns();
        int          fd;
        int          n;
        int          cidx;
        string       line;
        logic [7:0]  kind;
        logic [63:0] v [5];

        fd = $fopen("testbench/fetch_patterns.txt", "r");
        if (fd == 0) begin
            $display("could not open the pattern file");
            errors = errors + 1;
            return;
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n <= 1 || line[0] == "#") begin
                continue;
            end
            n = $sscanf(line, "%c %h %h %h %h %h", kind, v[0], v[1], v[2], v[3], v[4]);
            if (kind == "M") begin
                mem0.write_word(v[0], v[1], v[2][0]);
            end else if (kind == "E") begin
                exp_pc.push_back(v[0]);
                exp_instr.push_back(v[1]);
                exp_fault.push_back(v[2]);
            end else if (kind == "C") begin
                // Decode index is decimal, the rest is hex
                n = $sscanf(line, "%c %d %h %h %h %h", kind, cidx, v[1], v[2], v[3], v[4]);
                cmd_idx.push_back(cidx);
                cmd_kind.push_back(int'(v[1]));
                cmd_a.push_back(v[2]);
                cmd_b.push_back(v[3]);
                cmd_c.push_back(v[4]);
            end
        end
        $fclose(fd);
    endtask

    // Side monitors for the program buffer and stall behavior
    always @(negedge i_clk) begin
        if (i_nrst) begin
            if (i_progbuf_ena && !i_flush && o_mem_req.valid) begin
                pb_req_cnt <= pb_req_cnt + 1;
            end
            if (stall_left > 0 && o_mem_req.valid && i_mem_req_ready) begin
                stall_fire_cnt <= stall_fire_cnt + 1;
            end
            // Fetches in flight have drained by the last stalled cycle
            if (stall_left == 1) begin
                stall_end_req_valid <= o_mem_req.valid;
            end
        end
    end

    initial begin
        int idx;
        int cmd_ptr;
        int idle;
        int seg;
        int seg_err;
        bit pb_pending;
        bit pb_clear;

        i_nrst = 1'b0;
        i_flush = 1'b0;
        i_flush_pc = '0;
        i_progbuf_ena = 1'b0;
        i_progbuf_pc = '0;
        i_progbuf_instr = '0;
        i_dec_ready = 1'b0;
        errors = 0;
        stall_left = 0;
        pb_req_cnt = 0;
        stall_fire_cnt = 0;
        stall_end_req_valid = 1'b1;
        idx = 0;
        cmd_ptr = 0;
        idle = 0;
        seg = 1;
        seg_err = 0;
        pb_pending = 1'b0;
        pb_clear = 1'b0;
        void'($urandom(32'he333f68f));
        load_patterns();

        repeat (4) @(posedge i_clk);
        i_nrst <= 1'b1;

        while (idx < exp_pc.size()) begin
            @(negedge i_clk);
            if (o_dec_valid && i_dec_ready) begin
                check_value("o_dec.pc", exp_pc[idx], o_dec.pc);
                check_value("o_dec.instr", exp_instr[idx], 64'(o_dec.instr));
                check_value("o_dec.load_fault", exp_fault[idx], 64'(o_dec.load_fault));
                idx = idx + 1;
                idle = 0;
                if (pb_pending) begin
                    pb_pending = 1'b0;
                    pb_clear = 1'b1;
                end
            end else begin
                idle = idle + 1;
                if (idle > 200) begin
                    $display("timeout, nothing decoded for 200 cycles at index %0d", idx);
                    errors = errors + 1;
                    break;
                end
            end

            @(posedge i_clk);
            i_flush <= 1'b0;
            if (pb_clear) begin
                i_progbuf_ena <= 1'b0;
                pb_clear = 1'b0;
            end
            if (cmd_ptr < cmd_idx.size() && cmd_idx[cmd_ptr] == idx) begin
                $display("test %0d: %0d decoded so far, %0d errors", seg, idx, errors - seg_err);
                seg = seg + 1;
                seg_err = errors;
                i_dec_ready <= 1'b0;
                case (cmd_kind[cmd_ptr])
                    1: begin
                        i_flush <= 1'b1;
                        i_flush_pc <= cmd_a[cmd_ptr];
                    end
                    2: begin
                        // Flush to the resume address, then hand over to the buffer
                        i_flush <= 1'b1;
                        i_flush_pc <= cmd_c[cmd_ptr];
                        i_progbuf_ena <= 1'b1;
                        i_progbuf_pc <= cmd_a[cmd_ptr];
                        i_progbuf_instr <= cmd_b[cmd_ptr][31:0];
                        pb_pending = 1'b1;
                    end
                    default: begin
                        stall_left = int'(cmd_a[cmd_ptr]);
                    end
                endcase
                cmd_ptr = cmd_ptr + 1;
            end else if (stall_left > 0) begin
                i_dec_ready <= 1'b0;
                stall_left = stall_left - 1;
            end else begin
                i_dec_ready <= (($urandom % 4) != 0);
            end
        end
        $display("test %0d: %0d decoded so far, %0d errors", seg, idx, errors - seg_err);

        check_value("progbuf_mem_req_cycles", 64'd0, 64'(pb_req_cnt));
        $display("test progbuf: %0d memory request cycles", pb_req_cnt);
        check_value("o_mem_req.valid", 64'd0, 64'(stall_end_req_valid));
        if (stall_fire_cnt > QUEUE_DEPTH) begin
            $display("%0d requests accepted during the decode stall, more than the queue holds",
                     stall_fire_cnt);
            errors = errors + 1;
        end
        $display("test stall: %0d requests accepted", stall_fire_cnt);

        $display("done: %0d of %0d decoded, %0d errors", idx, exp_pc.size(), errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== testbench/fetch_patterns.txt ====
# M addr word fault | E pc instr fault
# C decode_index kind(1 flush, 2 progbuf, 3 stall) a b c
M 1000 1300100413001000 0
M 1008 1300100c13001008 0
M 1010 1300101413001010 1
M 1018 1300101c13001018 0
M 2000 1300200413002000 0
M 2008 1300200c13002008 0
M 3000 1300300413003000 0
C 8 1 2000 0 0
C 10 3 1e 0 0
C 12 2 800 00100073 3000
E 1000 13001000 0
E 1004 13001004 0
E 1008 13001008 0
E 100c 1300100c 0
E 1010 13001010 1
E 1014 13001014 1
E 1018 13001018 0
E 101c 1300101c 0
E 2000 13002000 0
E 2004 13002004 0
E 2008 13002008 0
E 200c 1300200c 0
E 800 00100073 0
E 3000 13003000 0
E 3004 13003004 0

// ==== filelist.f ====
rtl/fetch_pkg.sv
rtl/pc_predictor.sv
rtl/instr_fetch.sv
rtl/fetch_queue.sv
rtl/fetch_top.sv
testbench/fetch_mem_model.sv
testbench/tb_fetch_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the fetch front end testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f filelist.f --top-module tb_fetch_top \
    -o sim_fetch > build.log 2>&1 &&
./obj_dir/sim_fetch > sim.log 2>&1
grep -q "ALL CHECKS PASSED" sim.log && echo "simulation passed" || {
    echo "simulation failed, see build.log and sim.log"
    exit 1
}
